// File: verification/uart_dbg_trace.txt
# kind addr len exit_code n_send send_bytes n_reply reply_bytes
# byte lists in hex with the first byte leftmost, exit_code goes on eoc_i for EXEC
ACK   0000 0000 00000000 0 00 1 06
WRITE 0010 0004 00000000 4 deadbeef 2 0604
READ  0010 0004 00000000 0 00 6 06deadbeef04
READ  0011 0002 00000000 0 00 4 06adbe04
# Range crossing address 255, upper address byte is dropped
WRITE 01fc 0008 00000000 8 0123456789abcdef 2 0604
READ  00fc 0008 00000000 0 00 10 060123456789abcdef04
READ  00fe 0004 00000000 0 00 6 06456789ab04
WRITE 0000 0002 00000000 2 5aa5 2 0604
READ  00ff 0004 00000000 0 00 6 06675aa5cd04
WRITE 0040 0000 00000000 0 00 2 0604
READ  0040 0000 00000000 0 00 2 0604
EXEC  1234 0000 cafe0042 0 00 6 06144200feca
ACK   0000 0000 00000000 0 00 1 06
JUNK  0000 0000 00000000 1 5a 0 00
ACK   0000 0000 00000000 0 00 1 06
JUNK  0000 0000 00000000 1 14 0 00
ACK   0000 0000 00000000 0 00 1 06
EXEC  00a0 0000 00000001 0 00 6 061401000000
READ  0010 0001 00000000 0 00 3 06de04
ACK   0000 0000 00000000 0 00 1 06

// File: uart_dbg.f
+incdir+src
src/uart_dbg_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/dbg_scratch_mem.sv
src/dbg_cmd_engine.sv
src/uart_dbg_top.sv
verification/tb_uart_dbg.sv

// File: Bender.yml
package:
  name: uart_dbg

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/uart_dbg_pkg.sv
      - src/uart_rx.sv
      - src/uart_tx.sv
      - src/dbg_scratch_mem.sv
      - src/dbg_cmd_engine.sv
      - src/uart_dbg_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_uart_dbg.sv

// File: verification/tb_uart_dbg.sv
`timescale 1ns/1ns

`include "uart_dbg_macros.svh"

module tb_uart_dbg;

  import uart_dbg_pkg::*;

  localparam int unsigned Cpb       = `UART_DBG_CLKS_PER_BIT;
  localparam int unsigned FrameClks = 10 * Cpb;
  localparam int unsigned RespWait  = 60 * FrameClks;
  localparam int unsigned QuietWait = 30 * FrameClks;
  localparam int unsigned ExecWait  = 4 * FrameClks;

  logic        clk;
  logic        arst_n_i;
  logic        uart_rx_i;
  logic        uart_tx_o;
  exec_req_t   exec_o;
  eoc_t        eoc_i;
  int unsigned err_count;
  int unsigned exec_count;
  logic [15:0] exec_addr;

  uart_dbg_top u_uart_dbg_top (
    .clk       ( clk       ),
    .arst_n_i  ( arst_n_i  ),
    .uart_rx_i ( uart_rx_i ),
    .uart_tx_o ( uart_tx_o ),
    .exec_o    ( exec_o    ),
    .eoc_i     ( eoc_i     )
  );

  always #4 clk = ~clk;

  // Launch monitor
  always @(negedge clk) begin
    if (exec_o.valid) begin
      exec_count <= exec_count + 1;
      exec_addr  <= exec_o.addr;
    end
  end

  //////////////////////////////////////////////////
  // Serial line driver and monitor
  //////////////////////////////////////////////////

  task automatic drive_bit(input logic b);
    @(posedge clk);
    #1 uart_rx_i = b;
    repeat (Cpb - 1) @(posedge clk);
  endtask

  task automatic send_byte(input logic [7:0] b);
    int unsigned gap;
    int          i;
    gap = $urandom % 21;
    repeat (gap) drive_bit(1'b1);
    drive_bit(1'b0);
    for (i = 0; i < 8; i++) drive_bit(b[i]);
    drive_bit(1'b1);
  endtask

  task automatic send_all(input logic [7:0] bytes [$]);
    foreach (bytes[i]) send_byte(bytes[i]);
  endtask

  // Samples at the falling edge, mid-bit
  task automatic recv_byte(input int unsigned timeout, output logic [7:0] b, output bit got);
    int unsigned waited;
    int          i;
    got    = 1'b0;
    b      = '0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (uart_tx_o !== 1'b0 && waited < timeout);
    if (uart_tx_o !== 1'b0) return;
    repeat (Cpb / 2) @(negedge clk);
    assert (uart_tx_o === 1'b0) else begin
      $display("Start bit on uart_tx_o did not last half a bit period");
      err_count++;
    end
    for (i = 0; i < 8; i++) begin
      repeat (Cpb) @(negedge clk);
      b[i] = uart_tx_o;
    end
    repeat (Cpb) @(negedge clk);
    assert (uart_tx_o === 1'b1) else begin
      $display("Fail uart_tx_o stop bit: expected 1, got %h", uart_tx_o);
      err_count++;
    end
    got = 1'b1;
  endtask

  task automatic pulse_eoc(input logic [31:0] code);
    @(posedge clk);
    #1 eoc_i = '{valid: 1'b1, code: code};
    @(posedge clk);
    #1 eoc_i = '0;
  endtask

  task automatic wait_exec(input int unsigned base, input logic [15:0] entry);
    int unsigned waited;
    waited = 0;
    while (exec_count == base && waited < ExecWait) begin
      @(negedge clk);
      waited++;
    end
    if (exec_count == base) begin
      $display("Timeout waiting for the exec_o launch pulse");
      err_count++;
    end else begin
      assert (exec_addr == entry) else begin
        $display("Fail exec_o.addr: expected %04h, got %04h", entry, exec_addr);
        err_count++;
      end
    end
  endtask

  task automatic check_reply(input string kind, input logic [15:0] addr, input logic [31:0] code,
                             input int nexp, input logic [255:0] exp_v, input int unsigned base);
    logic [7:0] b;
    logic [7:0] want;
    bit         got;
    int         i;
    for (i = 0; i < nexp; i++) begin
      want = exp_v[8*(nexp-1-i) +: 8];
      recv_byte(RespWait, b, got);
      if (!got) begin
        $display("Timeout waiting for reply byte %0d of %s", i, kind);
        err_count++;
        break;
      end
      assert (b == want) else begin
        $display("Fail uart_tx_o byte %0d of %s: expected %02h, got %02h", i, kind, want, b);
        err_count++;
      end
      // Exit code only after the launch has been acknowledged
      if (kind == "EXEC" && i == 0) begin
        wait_exec(base, addr);
        pulse_eoc(code);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Trace replay
  //////////////////////////////////////////////////

  task automatic run_record(input string kind, input logic [15:0] addr, input logic [15:0] len,
                            input logic [31:0] code, input int ndata, input logic [255:0] data,
                            input int nexp, input logic [255:0] exp_v);
    logic [7:0]  cmd [$];
    logic [7:0]  b;
    bit          got;
    int unsigned base;
    int          i;
    base = exec_count;
    case (kind)
      "ACK":  cmd.push_back(OpAck);
      "READ", "WRITE", "EXEC": begin
        cmd.push_back(kind == "READ" ? OpRead : (kind == "WRITE" ? OpWrite : OpExec));
        cmd.push_back(addr[7:0]);
        cmd.push_back(addr[15:8]);
        if (kind != "EXEC") begin
          cmd.push_back(len[7:0]);
          cmd.push_back(len[15:8]);
        end
      end
      "JUNK": ;
      default: begin
        $display("Unknown command kind %s in trace", kind);
        err_count++;
      end
    endcase
    if (kind == "WRITE" || kind == "JUNK") begin
      for (i = 0; i < ndata; i++) cmd.push_back(data[8*(ndata-1-i) +: 8]);
    end
    if (kind == "JUNK") begin
      send_all(cmd);
      recv_byte(QuietWait, b, got);
      assert (!got) else begin
        $display("Unexpected reply %02h on uart_tx_o after a non-opcode byte", b);
        err_count++;
      end
    end else begin
      fork
        send_all(cmd);
        check_reply(kind, addr, code, nexp, exp_v, base);
      join
    end
    assert (exec_count == base + (kind == "EXEC" ? 1 : 0)) else begin
      $display("Fail exec_o.valid pulse count: expected %0h, got %0h",
               base + (kind == "EXEC" ? 1 : 0), exec_count);
      err_count++;
    end
  endtask

  task automatic check_idle_line();
    repeat (20 * Cpb) begin
      @(negedge clk);
      assert (uart_tx_o === 1'b1 && exec_o.valid === 1'b0) else begin
        $display("Fail idle uart_tx_o/exec_o.valid: expected 1/0, got %h/%h",
                 uart_tx_o, exec_o.valid);
        err_count++;
      end
    end
  endtask

  initial begin
    int           fd;
    int           nf;
    int           ndata;
    int           nexp;
    string        line;
    string        kind;
    logic [15:0]  addr;
    logic [15:0]  len;
    logic [31:0]  code;
    logic [255:0] data;
    logic [255:0] exp_v;
    clk        = 1'b0;
    arst_n_i   = 1'b0;
    uart_rx_i  = 1'b1;
    eoc_i      = '0;
    err_count  = 0;
    exec_count = 0;
    exec_addr  = '0;
    void'($urandom(32'h70fc9b6d));
    repeat (5) @(posedge clk);
    #1 arst_n_i = 1'b1;
    check_idle_line();
    fd = $fopen("verification/uart_dbg_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file");
      err_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        nf   = $fgets(line, fd);
        if (line.len() > 1 && line[0] != "#") begin
          nf = $sscanf(line, "%s %h %h %h %d %h %d %h",
                       kind, addr, len, code, ndata, data, nexp, exp_v);
          if (nf != 8) begin
            $display("Malformed trace line: %s", line);
            err_count++;
          end else begin
            run_record(kind, addr, len, code, ndata, data, nexp, exp_v);
          end
        end
      end
      $fclose(fd);
    end
    $display("Errors: %0d", err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: src/uart_dbg_top.sv
`timescale 1ns/1ns

`include "uart_dbg_macros.svh"

module uart_dbg_top (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   uart_rx_i,
  output logic                   uart_tx_o,
  output uart_dbg_pkg::exec_req_t exec_o,
  input  uart_dbg_pkg::eoc_t      eoc_i
);

  import uart_dbg_pkg::*;

  rx_byte_t   rx_byte;
  tx_byte_t   tx_byte;
  logic       tx_credit;
  mem_req_t   mem_req;
  logic [7:0] mem_rdata;

  uart_rx #(
    .ClksPerBit ( `UART_DBG_CLKS_PER_BIT )
  ) u_uart_rx (
    .clk      ( clk       ),
    .arst_n_i ( arst_n_i  ),
    .rx_i     ( uart_rx_i ),
    .byte_o   ( rx_byte   )
  );

  dbg_cmd_engine u_dbg_cmd_engine (
    .clk         ( clk       ),
    .arst_n_i    ( arst_n_i  ),
    .rx_byte_i   ( rx_byte   ),
    .tx_byte_o   ( tx_byte   ),
    .tx_credit_i ( tx_credit ),
    .mem_req_o   ( mem_req   ),
    .mem_rdata_i ( mem_rdata ),
    .exec_o      ( exec_o    ),
    .eoc_i       ( eoc_i     )
  );

  dbg_scratch_mem u_dbg_scratch_mem (
    .clk      ( clk       ),
    .arst_n_i ( arst_n_i  ),
    .req_i    ( mem_req   ),
    .rdata_o  ( mem_rdata )
  );

  uart_tx #(
    .ClksPerBit ( `UART_DBG_CLKS_PER_BIT )
  ) u_uart_tx (
    .clk      ( clk       ),
    .arst_n_i ( arst_n_i  ),
    .byte_i   ( tx_byte   ),
    .tx_o     ( uart_tx_o ),
    .credit_o ( tx_credit )
  );

endmodule

// File: src/dbg_cmd_engine.sv
`timescale 1ns/1ns

`include "uart_dbg_macros.svh"

module dbg_cmd_engine (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  uart_dbg_pkg::rx_byte_t  rx_byte_i,
  output uart_dbg_pkg::tx_byte_t  tx_byte_o,
  input  logic                   tx_credit_i,
  output uart_dbg_pkg::mem_req_t  mem_req_o,
  input  logic [7:0]             mem_rdata_i,
  output uart_dbg_pkg::exec_req_t exec_o,
  input  uart_dbg_pkg::eoc_t      eoc_i
);

  import uart_dbg_pkg::*;

  localparam int unsigned AddrW    = 8 * `UART_DBG_ADDR_BYTES;
  localparam int unsigned LenW     = 8 * `UART_DBG_LEN_BYTES;
  localparam int unsigned HdrRw    = `UART_DBG_ADDR_BYTES + `UART_DBG_LEN_BYTES;
  localparam int unsigned HdrEx    = `UART_DBG_ADDR_BYTES;
  localparam int unsigned CrdW     = $clog2(`UART_DBG_TX_CREDITS + 1);

  dbg_state_e                  state_q;
  dbg_op_e                     op_q;
  logic [LenW-1:0]             cnt_q;
  logic [`UART_DBG_MEM_AW-1:0] addr_q;
  logic [CrdW-1:0]             credit_q;
  logic [AddrW+LenW-1:0]       hdr_q;
  logic [8*`UART_DBG_EXIT_BYTES-1:0] exit_q;
  logic [LenW-1:0]             hdr_len;
  logic                        hdr_last;
  logic                        has_credit;
  logic                        tx_fire;

  assign hdr_len    = hdr_q[AddrW +: LenW];
  assign hdr_last   = (op_q == OpExec) ? (cnt_q == LenW'(HdrEx - 1)) :
                                         (cnt_q == LenW'(HdrRw - 1));
  assign has_credit = (credit_q != '0);
  assign tx_fire    = tx_byte_o.valid;

  //////////////////////////////////////////////////
  // Command FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= StIdle;
      op_q    <= OpAck;
      cnt_q   <= '0;
      addr_q  <= '0;
    end else begin
      case (state_q)
        StIdle: begin
          if (rx_byte_i.valid) begin
            cnt_q <= '0;
            case (rx_byte_i.data)
              OpAck: begin
                op_q    <= OpAck;
                state_q <= StSendAck;
              end
              OpRead, OpWrite, OpExec: begin
                op_q    <= dbg_op_e'(rx_byte_i.data);
                state_q <= StHdr;
              end
              // Anything else is line noise
              default: ;
            endcase
          end
        end
        StHdr: begin
          if (rx_byte_i.valid) begin
            cnt_q <= cnt_q + 1'b1;
            if (hdr_last) state_q <= StSendAck;
          end
        end
        StSendAck: begin
          if (tx_fire) begin
            addr_q <= hdr_q[`UART_DBG_MEM_AW-1:0];
            cnt_q  <= hdr_len;
            case (op_q)
              OpExec:  state_q <= StExecWait;
              OpRead:  state_q <= (hdr_len == '0) ? StSendEot : StRdReq;
              OpWrite: state_q <= (hdr_len == '0) ? StSendEot : StWrData;
              default: state_q <= StIdle;
            endcase
          end
        end
        StWrData: begin
          if (rx_byte_i.valid) begin
            addr_q <= addr_q + 1'b1;
            cnt_q  <= cnt_q - 1'b1;
            if (cnt_q == LenW'(1)) state_q <= StSendEot;
          end
        end
        StRdReq: begin
          addr_q  <= addr_q + 1'b1;
          state_q <= StRdWait;
        end
        StRdWait: begin
          // Read data stays on the port until the next request
          if (tx_fire) begin
            cnt_q   <= cnt_q - 1'b1;
            state_q <= (cnt_q == LenW'(1)) ? StSendEot : StRdReq;
          end
        end
        StSendEot: begin
          if (tx_fire) state_q <= StIdle;
        end
        StExecWait: begin
          if (eoc_i.valid) state_q <= StSendEoc;
        end
        StSendEoc: begin
          if (tx_fire) begin
            cnt_q   <= '0;
            state_q <= StSendExit;
          end
        end
        StSendExit: begin
          if (tx_fire) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == LenW'(`UART_DBG_EXIT_BYTES - 1)) state_q <= StIdle;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // Header fields and exit code
  always_ff @(posedge clk) begin
    if (state_q == StHdr && rx_byte_i.valid) hdr_q[cnt_q[1:0]*8 +: 8] <= rx_byte_i.data;
    if (state_q == StExecWait && eoc_i.valid) exit_q <= eoc_i.code;
  end

  // Transmitter credits
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_q <= CrdW'(`UART_DBG_TX_CREDITS);
    end else begin
      case ({tx_fire, tx_credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  always_comb begin
    tx_byte_o = '0;
    mem_req_o = '0;
    case (state_q)
      StSendAck: begin
        tx_byte_o.valid = has_credit;
        tx_byte_o.data  = OpAck;
      end
      StSendEot: begin
        tx_byte_o.valid = has_credit;
        tx_byte_o.data  = OpEot;
      end
      StSendEoc: begin
        tx_byte_o.valid = has_credit;
        tx_byte_o.data  = OpEoc;
      end
      StSendExit: begin
        tx_byte_o.valid = has_credit;
        tx_byte_o.data  = exit_q[cnt_q[1:0]*8 +: 8];
      end
      StRdWait: begin
        tx_byte_o.valid = has_credit;
        tx_byte_o.data  = mem_rdata_i;
      end
      StRdReq: begin
        mem_req_o.valid = 1'b1;
        mem_req_o.addr  = addr_q;
      end
      StWrData: begin
        mem_req_o.valid = rx_byte_i.valid;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = addr_q;
        mem_req_o.wdata = rx_byte_i.data;
      end
      default: ;
    endcase
  end

  // Launch goes out together with the EXEC acknowledge
  assign exec_o.valid = (state_q == StSendAck) && (op_q == OpExec) && tx_fire;
  assign exec_o.addr  = hdr_q[AddrW-1:0];

endmodule

// File: src/dbg_scratch_mem.sv
`timescale 1ns/1ns

`include "uart_dbg_macros.svh"

module dbg_scratch_mem (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  uart_dbg_pkg::mem_req_t req_i,
  output logic [7:0]            rdata_o
);

  import uart_dbg_pkg::*;

  localparam int unsigned Depth = 2 ** `UART_DBG_MEM_AW;

  logic [7:0] mem_q [Depth];
  logic [7:0] rdata_q;

  always_ff @(posedge clk) begin
    if (req_i.valid && req_i.we) mem_q[req_i.addr] <= req_i.wdata;
  end

  // Read port holds its data until the next read
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_q <= '0;
    end else if (req_i.valid && !req_i.we) begin
      rdata_q <= mem_q[req_i.addr];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ns

`include "uart_dbg_macros.svh"

module uart_tx #(
  parameter int unsigned ClksPerBit = `UART_DBG_CLKS_PER_BIT
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  uart_dbg_pkg::tx_byte_t byte_i,
  output logic                  tx_o,
  output logic                  credit_o
);

  import uart_dbg_pkg::*;

  localparam int unsigned CntW = $clog2(ClksPerBit);

  logic            busy_q;
  logic            tx_q;
  logic            credit_q;
  logic [CntW-1:0] clk_cnt_q;
  logic [3:0]      bit_cnt_q;
  logic [8:0]      shift_q;
  logic            accept;
  logic            bit_end;

  assign accept  = byte_i.valid && !busy_q;
  assign bit_end = busy_q && (clk_cnt_q == CntW'(ClksPerBit - 1));

  //////////////////////////////////////////////////
  // Frame sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q    <= 1'b0;
      tx_q      <= 1'b1;
      credit_q  <= 1'b0;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else begin
      credit_q <= 1'b0;
      if (accept) begin
        // Start bit goes out right away
        busy_q    <= 1'b1;
        tx_q      <= 1'b0;
        clk_cnt_q <= '0;
        bit_cnt_q <= '0;
      end else if (bit_end) begin
        clk_cnt_q <= '0;
        if (bit_cnt_q == 4'd9) begin
          busy_q   <= 1'b0;
          credit_q <= 1'b1;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
          tx_q      <= shift_q[0];
        end
      end else if (busy_q) begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
    end
  end

  // Data bits then stop bit, LSB first
  always_ff @(posedge clk) begin
    if (accept) shift_q <= {1'b1, byte_i.data};
    else if (bit_end) shift_q <= {1'b1, shift_q[8:1]};
  end

  assign tx_o     = tx_q;
  assign credit_o = credit_q;

endmodule

// File: src/uart_rx.sv
`timescale 1ns/1ns

`include "uart_dbg_macros.svh"

module uart_rx #(
  parameter int unsigned ClksPerBit = `UART_DBG_CLKS_PER_BIT
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  rx_i,
  output uart_dbg_pkg::rx_byte_t byte_o
);

  import uart_dbg_pkg::*;

  localparam int unsigned CntW = $clog2(ClksPerBit);

  typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rx_state_e;

  rx_state_e       state_q;
  logic [1:0]      sync_q;
  logic [CntW-1:0] clk_cnt_q;
  logic [2:0]      bit_cnt_q;
  logic [7:0]      shift_q;
  logic            valid_q;
  logic            rx_s;

  // Line is asynchronous to clk
  assign rx_s = sync_q[1];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q    <= 2'b11;
      state_q   <= RxIdle;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      shift_q   <= '0;
      valid_q   <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], rx_i};
      valid_q <= 1'b0;
      case (state_q)
        RxIdle: begin
          clk_cnt_q <= '0;
          if (!rx_s) state_q <= RxStart;
        end
        RxStart: begin
          // Re-check the start bit at its middle
          if (clk_cnt_q == CntW'(ClksPerBit / 2 - 1)) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            state_q   <= rx_s ? RxIdle : RxData;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RxData: begin
          if (clk_cnt_q == CntW'(ClksPerBit - 1)) begin
            clk_cnt_q <= '0;
            shift_q   <= {rx_s, shift_q[7:1]};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) state_q <= RxStop;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RxStop: begin
          if (clk_cnt_q == CntW'(ClksPerBit - 1)) begin
            // Framing error drops the byte
            valid_q <= rx_s;
            state_q <= RxIdle;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= RxIdle;
      endcase
    end
  end

  assign byte_o.valid = valid_q;
  assign byte_o.data  = shift_q;

endmodule

// File: src/uart_dbg_pkg.sv
`include "uart_dbg_macros.svh"

package uart_dbg_pkg;

  // Protocol bytes on the serial line
  typedef enum logic [7:0] {
    OpEot   = 8'h04,
    OpAck   = 8'h06,
    OpRead  = 8'h11,
    OpWrite = 8'h12,
    OpExec  = 8'h13,
    OpEoc   = 8'h14
  } dbg_op_e;

  // Command engine states
  typedef enum logic [3:0] {
    StIdle,
    StHdr,
    StSendAck,
    StWrData,
    StRdReq,
    StRdWait,
    StSendEot,
    StExecWait,
    StSendEoc,
    StSendExit
  } dbg_state_e;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } rx_byte_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } tx_byte_t;

  typedef struct packed {
    logic                        valid;
    logic                        we;
    logic [`UART_DBG_MEM_AW-1:0] addr;
    logic [7:0]                  wdata;
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] addr;
  } exec_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] code;
  } eoc_t;

endpackage

// File: src/uart_dbg_macros.svh
`ifndef UART_DBG_MACROS_SVH
`define UART_DBG_MACROS_SVH

// Clock cycles per UART bit period
`define UART_DBG_CLKS_PER_BIT 8

// Field sizes of the debug protocol, in bytes
`define UART_DBG_ADDR_BYTES 2
`define UART_DBG_LEN_BYTES 2
`define UART_DBG_EXIT_BYTES 4

// Scratch memory address bits, 256 bytes
`define UART_DBG_MEM_AW 8

// Buffer slots in the transmitter
`define UART_DBG_TX_CREDITS 1

`endif
